//--- pin_bus_pkg.sv
`default_nettype none

package pin_bus_pkg;

  // bank size and bus widths
  localparam int NUM_CHANNELS = 4;
  localparam int ADDR_WIDTH = 19;
  localparam int DATA_WIDTH = 32;
  localparam int RD_WIDTH = 16;

  // register indices in the low address byte of a channel
  localparam logic [7:0] ADDR_NCO_STEP = 8'd1;
  localparam logic [7:0] ADDR_END_TIME = 8'd2;
  localparam logic [7:0] ADDR_LOCAL_CMD = 8'd3;
  localparam logic [7:0] ADDR_SAMPLE_RATE = 8'd4;
  localparam logic [7:0] ADDR_SAMPLE_REG = 8'd5;
  localparam logic [7:0] ADDR_SAMPLE_CNT = 8'd7;
  localparam logic [7:0] ADDR_STATUS_REG = 8'd8;
  localparam logic [7:0] ADDR_LAST_DATA = 8'd9;

  // fixed middle field of the sample word
  localparam logic [14:0] SAMPLE_TAG = {12'habc, 3'b111};

endpackage

`default_nettype wire

//--- pin_cmd_pkg.sv
`default_nettype none

package pin_cmd_pkg;

  // only the low byte of a command write is kept
  localparam int CMD_WIDTH = 8;

  localparam logic [CMD_WIDTH-1:0] CMD_CONST = 8'd2;
  localparam logic [CMD_WIDTH-1:0] CMD_SQUARE_WAVE = 8'd3;
  localparam logic [CMD_WIDTH-1:0] CMD_INPUT_STREAM = 8'd4;
  localparam logic [CMD_WIDTH-1:0] CMD_RESET = 8'd5;

  // one-hot sequencer states
  localparam int STATE_WIDTH = 4;

  localparam logic [STATE_WIDTH-1:0] ST_IDLE = 4'b0001;
  localparam logic [STATE_WIDTH-1:0] ST_CONST = 4'b0010;
  localparam logic [STATE_WIDTH-1:0] ST_SQUARE = 4'b0100;
  localparam logic [STATE_WIDTH-1:0] ST_STREAM = 4'b1000;

endpackage

`default_nettype wire

//--- pin_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pin_reg_decode #(
  parameter int position = 0
) (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 enable,
  input  wire logic [pin_bus_pkg::ADDR_WIDTH-1:0]   addr,
  input  wire logic                                 data_wr,
  input  wire logic                                 data_rd,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   data_in,
  input  wire logic                                 cmd_clear,
  output logic      [pin_cmd_pkg::CMD_WIDTH-1:0]    command,
  output logic      [pin_bus_pkg::DATA_WIDTH-1:0]   nco_step,
  output logic      [pin_bus_pkg::DATA_WIDTH-1:0]   end_time,
  output logic      [pin_bus_pkg::DATA_WIDTH-1:0]   sample_rate,
  output logic      [pin_bus_pkg::DATA_WIDTH-1:0]   last_data,
  output logic                                      rd_strobe,
  output logic      [7:0]                           reg_index
);

  logic selected;
  logic wr_sel;

  // channel is picked by address bits 15 to 8
  assign selected = enable && (addr[15:8] == 8'(position));
  assign wr_sel = selected && data_wr;

  assign rd_strobe = selected && data_rd;
  assign reg_index = addr[7:0];

  // every selected write is remembered for readback
  always_ff @(posedge clk) begin
    if (wr_sel) begin
      last_data <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      command <= '0;
      nco_step <= '0;
      end_time <= '0;
      sample_rate <= '0;
    end else begin
      // the sequencer consuming a command wins over a new write
      if (cmd_clear) begin
        command <= '0;
      end else if (wr_sel && (addr[7:0] == pin_bus_pkg::ADDR_LOCAL_CMD)) begin
        command <= data_in[pin_cmd_pkg::CMD_WIDTH-1:0];
      end
      if (wr_sel && (addr[7:0] == pin_bus_pkg::ADDR_NCO_STEP)) begin
        nco_step <= data_in;
      end
      if (wr_sel && (addr[7:0] == pin_bus_pkg::ADDR_END_TIME)) begin
        end_time <= data_in;
      end
      if (wr_sel && (addr[7:0] == pin_bus_pkg::ADDR_SAMPLE_RATE)) begin
        sample_rate <= data_in;
      end
    end
  end

endmodule

`default_nettype wire

//--- pin_waveform_exec.sv
`timescale 1ns/1ps
`default_nettype none

module pin_waveform_exec (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   current_time,
  input  wire logic [pin_cmd_pkg::CMD_WIDTH-1:0]    command,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   end_time,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   nco_step,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   sample_rate,
  output logic                                      cmd_clear,
  output logic                                      pin_out,
  output logic                                      pin_oe,
  output logic                                      sample_strobe
);

  logic [pin_cmd_pkg::STATE_WIDTH-1:0] state;
  logic [pin_cmd_pkg::STATE_WIDTH-1:0] state_next;
  logic                                clear_next;
  logic [pin_bus_pkg::DATA_WIDTH-1:0]  phase_acc;
  logic [pin_bus_pkg::DATA_WIDTH-1:0]  rate_cnt;
  logic                                time_running;
  logic                                time_expired;
  logic                                cmd_pending;
  logic                                reset_req;

  assign time_running = (current_time != '0);
  assign time_expired = (current_time >= end_time);
  // the held command is stale while its clear is in flight
  assign cmd_pending = !cmd_clear;
  assign reset_req = cmd_pending && (command == pin_cmd_pkg::CMD_RESET);

  always_comb begin
    state_next = state;
    clear_next = 1'b0;
    unique case (state)
      pin_cmd_pkg::ST_IDLE: begin
        if (cmd_pending && time_running) begin
          if (command == pin_cmd_pkg::CMD_CONST) begin
            state_next = pin_cmd_pkg::ST_CONST;
            clear_next = 1'b1;
          end else if (command == pin_cmd_pkg::CMD_SQUARE_WAVE) begin
            state_next = pin_cmd_pkg::ST_SQUARE;
            clear_next = 1'b1;
          end else if (command == pin_cmd_pkg::CMD_INPUT_STREAM) begin
            state_next = pin_cmd_pkg::ST_STREAM;
            clear_next = 1'b1;
          end
        end
        // a reset with nothing running is simply dropped
        if (reset_req) begin
          clear_next = 1'b1;
        end
      end
      pin_cmd_pkg::ST_CONST, pin_cmd_pkg::ST_SQUARE: begin
        if (reset_req) begin
          state_next = pin_cmd_pkg::ST_IDLE;
          clear_next = 1'b1;
        end else if (time_expired) begin
          state_next = pin_cmd_pkg::ST_IDLE;
        end
      end
      pin_cmd_pkg::ST_STREAM: begin
        // streaming only ends on a reset command
        if (reset_req) begin
          state_next = pin_cmd_pkg::ST_IDLE;
          clear_next = 1'b1;
        end
      end
      default: state_next = pin_cmd_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pin_cmd_pkg::ST_IDLE;
      cmd_clear <= 1'b0;
      phase_acc <= '0;
      rate_cnt <= '0;
      sample_strobe <= 1'b0;
    end else begin
      state <= state_next;
      cmd_clear <= clear_next;
      // accumulator follows the next state so the pin moves one cycle sooner
      if (state_next == pin_cmd_pkg::ST_CONST) begin
        phase_acc <= '1;
      end else if (state_next == pin_cmd_pkg::ST_SQUARE) begin
        phase_acc <= phase_acc + nco_step;
      end else begin
        phase_acc <= '0;
      end
      // rate counter counts down from sample_rate and fires at one
      sample_strobe <= 1'b0;
      if (state == pin_cmd_pkg::ST_STREAM) begin
        if (rate_cnt <= 1) begin
          sample_strobe <= 1'b1;
          rate_cnt <= sample_rate;
        end else begin
          rate_cnt <= rate_cnt - 1'b1;
        end
      end else begin
        rate_cnt <= sample_rate;
      end
    end
  end

  assign pin_oe = (state == pin_cmd_pkg::ST_CONST) || (state == pin_cmd_pkg::ST_SQUARE);
  assign pin_out = pin_oe && phase_acc[pin_bus_pkg::DATA_WIDTH-1];

endmodule

`default_nettype wire

//--- pin_sample_result.sv
`timescale 1ns/1ps
`default_nettype none

module pin_sample_result #(
  parameter int position = 0
) (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 rd_strobe,
  input  wire logic [7:0]                           reg_index,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   last_data,
  input  wire logic                                 pin_in,
  input  wire logic                                 sample_strobe,
  input  wire logic                                 output_sample,
  input  wire logic [7:0]                           channel_select,
  output logic      [pin_bus_pkg::RD_WIDTH-1:0]     data_out,
  output logic      [pin_bus_pkg::DATA_WIDTH-1:0]   sample_data
);

  logic                             sample_bit;
  logic [pin_bus_pkg::RD_WIDTH-1:0] sample_cnt;
  logic [pin_bus_pkg::RD_WIDTH-1:0] rd_value;

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_bit <= 1'b0;
      sample_cnt <= '0;
    end else if (sample_strobe) begin
      sample_bit <= pin_in;
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  // register map for reads
  always_comb begin
    case (reg_index)
      pin_bus_pkg::ADDR_SAMPLE_REG: rd_value = {{(pin_bus_pkg::RD_WIDTH-1){1'b0}}, sample_bit};
      pin_bus_pkg::ADDR_SAMPLE_CNT: rd_value = sample_cnt;
      pin_bus_pkg::ADDR_STATUS_REG: rd_value = pin_bus_pkg::RD_WIDTH'(position);
      pin_bus_pkg::ADDR_LAST_DATA:  rd_value = last_data[pin_bus_pkg::RD_WIDTH-1:0];
      default:                      rd_value = '0;
    endcase
  end

  // both outputs are zero unless this channel was addressed last cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
      sample_data <= '0;
    end else begin
      if (rd_strobe) begin
        data_out <= rd_value;
      end else begin
        data_out <= '0;
      end
      if (output_sample && (channel_select == 8'(position))) begin
        sample_data <= {sample_cnt, pin_bus_pkg::SAMPLE_TAG, sample_bit};
      end else begin
        sample_data <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- pin_channel.sv
`timescale 1ns/1ps
`default_nettype none

module pin_channel #(
  parameter int position = 0
) (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 enable,
  input  wire logic [pin_bus_pkg::ADDR_WIDTH-1:0]   addr,
  input  wire logic                                 data_wr,
  input  wire logic                                 data_rd,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   data_in,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   current_time,
  input  wire logic                                 output_sample,
  input  wire logic [7:0]                           channel_select,
  input  wire logic                                 pin_in,
  output logic      [pin_bus_pkg::RD_WIDTH-1:0]     data_out,
  output logic      [pin_bus_pkg::DATA_WIDTH-1:0]   sample_data,
  output logic                                      pin_out,
  output logic                                      pin_oe
);

  logic [pin_cmd_pkg::CMD_WIDTH-1:0]  command;
  logic [pin_bus_pkg::DATA_WIDTH-1:0] nco_step;
  logic [pin_bus_pkg::DATA_WIDTH-1:0] end_time;
  logic [pin_bus_pkg::DATA_WIDTH-1:0] sample_rate;
  logic [pin_bus_pkg::DATA_WIDTH-1:0] last_data;
  logic                               rd_strobe;
  logic [7:0]                         reg_index;
  logic                               cmd_clear;
  logic                               sample_strobe;

  pin_reg_decode #(.position(position)) decode_i (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .addr        (addr),
    .data_wr     (data_wr),
    .data_rd     (data_rd),
    .data_in     (data_in),
    .cmd_clear   (cmd_clear),
    .command     (command),
    .nco_step    (nco_step),
    .end_time    (end_time),
    .sample_rate (sample_rate),
    .last_data   (last_data),
    .rd_strobe   (rd_strobe),
    .reg_index   (reg_index)
  );

  pin_waveform_exec exec_i (
    .clk           (clk),
    .reset         (reset),
    .current_time  (current_time),
    .command       (command),
    .end_time      (end_time),
    .nco_step      (nco_step),
    .sample_rate   (sample_rate),
    .cmd_clear     (cmd_clear),
    .pin_out       (pin_out),
    .pin_oe        (pin_oe),
    .sample_strobe (sample_strobe)
  );

  pin_sample_result #(.position(position)) result_i (
    .clk            (clk),
    .reset          (reset),
    .rd_strobe      (rd_strobe),
    .reg_index      (reg_index),
    .last_data      (last_data),
    .pin_in         (pin_in),
    .sample_strobe  (sample_strobe),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .data_out       (data_out),
    .sample_data    (sample_data)
  );

endmodule

`default_nettype wire

//--- pin_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module pin_bank_top (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 enable,
  input  wire logic [pin_bus_pkg::ADDR_WIDTH-1:0]   addr,
  input  wire logic                                 data_wr,
  input  wire logic                                 data_rd,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   data_in,
  input  wire logic [pin_bus_pkg::DATA_WIDTH-1:0]   current_time,
  input  wire logic                                 output_sample,
  input  wire logic [7:0]                           channel_select,
  input  wire logic [pin_bus_pkg::NUM_CHANNELS-1:0] pin_in,
  output logic      [pin_bus_pkg::RD_WIDTH-1:0]     data_out,
  output logic      [pin_bus_pkg::DATA_WIDTH-1:0]   sample_data,
  output logic      [pin_bus_pkg::NUM_CHANNELS-1:0] pin_out,
  output logic      [pin_bus_pkg::NUM_CHANNELS-1:0] pin_oe
);

  logic [pin_bus_pkg::RD_WIDTH-1:0]   ch_data_out [pin_bus_pkg::NUM_CHANNELS];
  logic [pin_bus_pkg::DATA_WIDTH-1:0] ch_sample   [pin_bus_pkg::NUM_CHANNELS];

  for (genvar i = 0; i < pin_bus_pkg::NUM_CHANNELS; i++) begin : g_channel
    pin_channel #(.position(i)) channel_i (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .addr           (addr),
      .data_wr        (data_wr),
      .data_rd        (data_rd),
      .data_in        (data_in),
      .current_time   (current_time),
      .output_sample  (output_sample),
      .channel_select (channel_select),
      .pin_in         (pin_in[i]),
      .data_out       (ch_data_out[i]),
      .sample_data    (ch_sample[i]),
      .pin_out        (pin_out[i]),
      .pin_oe         (pin_oe[i])
    );
  end

  // idle channels drive zero so a plain OR merges them
  always_comb begin
    data_out = '0;
    sample_data = '0;
    for (int i = 0; i < pin_bus_pkg::NUM_CHANNELS; i++) begin
      data_out = data_out | ch_data_out[i];
      sample_data = sample_data | ch_sample[i];
    end
  end

endmodule

`default_nettype wire

//--- pin_bank_tb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module pin_channel_asserts #(
  parameter int position = 0
) (
  input wire logic        clk,
  input wire logic        reset,
  input wire logic        pin_oe,
  input wire logic        cmd_clear,
  input wire logic [3:0]  state,
  input wire logic        output_sample,
  input wire logic [7:0]  channel_select,
  input wire logic [31:0] sample_data
);

  // streaming only listens to the pin
  a_no_drive_in_stream: assert property (@(posedge clk) disable iff (reset)
    (state == pin_cmd_pkg::ST_STREAM) |-> !pin_oe)
    else $error("pin_oe high in stream state, channel %0d", position);

  a_clear_single_cycle: assert property (@(posedge clk) disable iff (reset)
    cmd_clear |=> !cmd_clear)
    else $error("cmd_clear longer than one cycle, channel %0d", position);

  a_sample_idle_zero: assert property (@(posedge clk) disable iff (reset)
    !(output_sample && (channel_select == 8'(position))) |=> (sample_data == '0))
    else $error("sample_data nonzero without select, channel %0d", position);

endmodule

bind pin_channel pin_channel_asserts #(.position(position)) asserts_i (
  .clk            (clk),
  .reset          (reset),
  .pin_oe         (pin_oe),
  .cmd_clear      (cmd_clear),
  .state          (exec_i.state),
  .output_sample  (output_sample),
  .channel_select (channel_select),
  .sample_data    (sample_data)
);

`default_nettype wire

//--- pin_bank_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pin_bank_tb;

  localparam int CLK_PERIOD = 8;
  // reset, readback, constant, square, stream, reset command, pending
  localparam int TEST_CYCLES = 10 + 60 + 90 + 420 + 220 + 80 + 30;
  localparam int MARGIN_CYCLES = 200;

  logic        clk;
  logic        reset;
  logic        enable;
  logic [18:0] addr;
  logic        data_wr;
  logic        data_rd;
  logic [31:0] data_in;
  logic [31:0] current_time = '0;
  logic        output_sample;
  logic [7:0]  channel_select;
  logic [3:0]  pin_in;
  logic [15:0] data_out;
  logic [31:0] sample_data;
  logic [3:0]  pin_out;
  logic [3:0]  pin_oe;

  logic        hold_time;
  logic [31:0] rng_state = 32'hc9c39529;
  string       test_name;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;

  pin_bank_top dut_i (
    .clk            (clk),
    .reset          (reset),
    .enable         (enable),
    .addr           (addr),
    .data_wr        (data_wr),
    .data_rd        (data_rd),
    .data_in        (data_in),
    .current_time   (current_time),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .pin_in         (pin_in),
    .data_out       (data_out),
    .sample_data    (sample_data),
    .pin_out        (pin_out),
    .pin_oe         (pin_oe)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // free-running time held at zero while hold_time is set
  always @(negedge clk) begin
    if (hold_time) begin
      current_time <= '0;
    end else begin
      current_time <= current_time + 1;
    end
  end

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish",
             TEST_CYCLES + MARGIN_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // rising edges of the top bit of an accumulator stepped from zero
  function automatic int model_nco_edges(input logic [31:0] step, input int cycles);
    logic [31:0] acc;
    logic        prev;
    int          edges;
    acc = '0;
    prev = 1'b0;
    edges = 0;
    for (int i = 0; i < cycles; i++) begin
      acc = acc + step;
      if (acc[31] && !prev) begin
        edges++;
      end
      prev = acc[31];
    end
    return edges;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errors);
    end
    total_errors += test_errors;
  endtask

  task automatic check_value(input string label, input longint expected,
                             input longint actual, input longint tol);
    if (actual > expected + tol || actual + tol < expected) begin
      $display("Mismatch %s %s: expected %0d, actual %0d", test_name, label,
               expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error in %s: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic bus_write(input int ch, input logic [7:0] idx, input logic [31:0] value);
    @(negedge clk);
    addr = {3'b000, 8'(ch), idx};
    data_in = value;
    enable = 1'b1;
    data_wr = 1'b1;
    @(negedge clk);
    enable = 1'b0;
    data_wr = 1'b0;
  endtask

  // a read also asks the sample port of the same channel in the same cycle
  task automatic bus_read(input int ch, input logic [7:0] idx,
                          output logic [15:0] rd, output logic [31:0] word);
    @(negedge clk);
    addr = {3'b000, 8'(ch), idx};
    enable = 1'b1;
    data_rd = 1'b1;
    output_sample = 1'b1;
    channel_select = 8'(ch);
    @(negedge clk);
    enable = 1'b0;
    data_rd = 1'b0;
    output_sample = 1'b0;
    rd = data_out;
    word = sample_data;
  endtask

  task automatic wait_oe(input int ch, input logic level, input int limit, output logic ok);
    int i;
    ok = 1'b0;
    i = 0;
    while (!ok && i < limit) begin
      @(negedge clk);
      ok = (pin_oe[ch] == level);
      i++;
    end
  endtask

  initial begin
    logic [31:0] written [4];
    logic [15:0] rd;
    logic [15:0] cnt_first;
    logic [31:0] word;
    logic [31:0] end_val;
    logic [31:0] step;
    logic        ok;
    logic        early;
    logic        late;
    logic        prev;
    int          edges;

    reset = 1'b1;
    hold_time <= 1'b1;
    enable = 1'b0;
    addr = '0;
    data_wr = 1'b0;
    data_rd = 1'b0;
    data_in = '0;
    output_sample = 1'b0;
    channel_select = '0;
    pin_in = '0;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    hold_time <= 1'b0;

    start_test("register_readback");
    for (int ch = 0; ch < 4; ch++) begin
      written[ch] = next_random();
      bus_write(ch, pin_bus_pkg::ADDR_LAST_DATA, written[ch]);
      bus_read(ch, pin_bus_pkg::ADDR_LAST_DATA, rd, word);
      check_value($sformatf("ch%0d last data", ch), written[ch][15:0], rd, 0);
    end
    for (int ch = 0; ch < 4; ch++) begin
      bus_read(ch, pin_bus_pkg::ADDR_STATUS_REG, rd, word);
      check_value($sformatf("ch%0d status", ch), ch, rd, 0);
      bus_read(ch, 8'd6, rd, word);
      check_value($sformatf("ch%0d unmapped", ch), 0, rd, 0);
      // later writes to other channels must not disturb this one
      bus_read(ch, pin_bus_pkg::ADDR_LAST_DATA, rd, word);
      check_value($sformatf("ch%0d last data kept", ch), written[ch][15:0], rd, 0);
    end
    finish_test();

    start_test("constant_command");
    end_val = current_time + 50;
    bus_write(0, pin_bus_pkg::ADDR_END_TIME, end_val);
    bus_write(0, pin_bus_pkg::ADDR_LOCAL_CMD, pin_cmd_pkg::CMD_CONST);
    wait_oe(0, 1'b1, 3, ok);
    if (!ok) begin
      report_failure("pin_oe of channel 0 did not rise after the constant command");
    end
    early = 1'b0;
    late = 1'b0;
    for (int i = 0; i < 70; i++) begin
      @(negedge clk);
      if (current_time + 2 < end_val && !(pin_oe[0] && pin_out[0])) begin
        early = 1'b1;
      end
      if (current_time > end_val + 2 && pin_oe[0]) begin
        late = 1'b1;
      end
    end
    if (early) begin
      report_failure("channel 0 pin dropped before the end time");
    end
    if (late) begin
      report_failure("channel 0 pin_oe still high after the end time");
    end
    finish_test();

    start_test("square_wave");
    step = next_random() >> 3;
    bus_write(1, pin_bus_pkg::ADDR_NCO_STEP, step);
    bus_write(1, pin_bus_pkg::ADDR_END_TIME, current_time + 3000);
    bus_write(1, pin_bus_pkg::ADDR_LOCAL_CMD, pin_cmd_pkg::CMD_SQUARE_WAVE);
    wait_oe(1, 1'b1, 3, ok);
    if (!ok) begin
      report_failure("pin_oe of channel 1 did not rise after the square wave command");
    end
    edges = 0;
    prev = 1'b0;
    for (int i = 0; i < 400; i++) begin
      if (pin_out[1] && !prev) begin
        edges++;
      end
      prev = pin_out[1];
      @(negedge clk);
    end
    check_value("rising edges", model_nco_edges(step, 400), edges, 1);
    finish_test();

    start_test("input_stream");
    pin_in = 4'(next_random());
    bus_write(2, pin_bus_pkg::ADDR_SAMPLE_RATE, 32'd8);
    bus_write(2, pin_bus_pkg::ADDR_LOCAL_CMD, pin_cmd_pkg::CMD_INPUT_STREAM);
    wait_cycles(200);
    bus_read(2, pin_bus_pkg::ADDR_SAMPLE_REG, rd, word);
    check_value("sample bit", pin_in[2], rd, 0);
    bus_read(2, pin_bus_pkg::ADDR_SAMPLE_CNT, rd, word);
    check_value("sample count", 200 / 8, rd, 2);
    // the word was taken in the same cycle as the count read
    check_value("sample word count", 200 / 8, word[31:16], 2);
    check_value("sample word tag and bit", {pin_bus_pkg::SAMPLE_TAG, pin_in[2]},
                word[15:0], 0);
    finish_test();

    start_test("reset_command");
    bus_write(2, pin_bus_pkg::ADDR_LOCAL_CMD, pin_cmd_pkg::CMD_RESET);
    wait_cycles(3);
    bus_read(2, pin_bus_pkg::ADDR_SAMPLE_CNT, cnt_first, word);
    wait_cycles(50);
    bus_read(2, pin_bus_pkg::ADDR_SAMPLE_CNT, rd, word);
    check_value("frozen count", cnt_first, rd, 0);
    if (!pin_oe[1]) begin
      report_failure("square wave on channel 1 stopped before the reset command");
    end
    bus_write(1, pin_bus_pkg::ADDR_LOCAL_CMD, pin_cmd_pkg::CMD_RESET);
    wait_oe(1, 1'b0, 3, ok);
    if (!ok) begin
      report_failure("pin_oe of channel 1 stayed high after the reset command");
    end
    finish_test();

    start_test("pending_command");
    hold_time <= 1'b1;
    wait_cycles(2);
    bus_write(3, pin_bus_pkg::ADDR_END_TIME, 32'd200);
    bus_write(3, pin_bus_pkg::ADDR_LOCAL_CMD, pin_cmd_pkg::CMD_CONST);
    early = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      if (pin_oe[3]) begin
        early = 1'b1;
      end
    end
    if (early) begin
      report_failure("channel 3 started while time was held at zero");
    end
    hold_time <= 1'b0;
    wait_oe(3, 1'b1, 3, ok);
    if (!ok) begin
      report_failure("pending command on channel 3 did not start once time ran");
    end
    finish_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
pin_bus_pkg.sv
pin_cmd_pkg.sv
pin_reg_decode.sv
pin_waveform_exec.sv
pin_sample_result.sv
pin_channel.sv
pin_bank_top.sv
pin_bank_tb_asserts.sv
pin_bank_tb.sv
